//--- all.f
verilog/rsa_pkg.sv
verilog/mont_mult.sv
verilog/mod_prep.sv
verilog/rsa_core.sv
verilog/rsa_avm_wrapper.sv
verilog/rsa_top.sv
verif/avm_uart_model.sv
verif/tb_rsa_top.sv

//--- run_verilator.sh
#!/bin/sh
# Build and run the RSA testbench, pass only if the sim printed the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rsa_top -f all.f -o sim_rsa \
    && ./obj_dir/sim_rsa | tee /dev/stderr | grep -F ">>> PASS" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- verif/avm_uart_model.sv
`timescale 1ns/1ps
`default_nettype none

module avm_uart_model
    import rsa_pkg::*;
(
    input  wire                      avm_clk,
    input  wire                      avm_rst,
    input  wire  [AVM_ADDR_BITS-1:0] avm_address,
    input  wire                      avm_read,
    input  wire                      avm_write,
    input  wire  [31:0]              avm_writedata,
    output logic [31:0]              avm_readdata,
    output logic                     avm_waitrequest,
    output logic                     proto_error
);

    logic [7:0] rx_q[$];
    logic [7:0] tx_q[$];
    int         status_reads;
    int         wait_left;
    logic       in_transfer;
    logic       rx_granted;
    logic       tx_granted;

    initial begin
        avm_readdata    = 32'd0;
        avm_waitrequest = 1'b0;
        proto_error     = 1'b0;
        status_reads    = 0;
        wait_left       = 0;
        in_transfer     = 1'b0;
        rx_granted      = 1'b0;
        tx_granted      = 1'b0;
    end

    task automatic push_rx_byte(input logic [7:0] value);
        rx_q.push_back(value);
    endtask

    function automatic int tx_count();
        return tx_q.size();
    endfunction

    function automatic logic [7:0] tx_byte(input int idx);
        return tx_q[idx];
    endfunction

    // Runs in the cycle whose waitrequest is low, so the access completes
    task automatic complete_transfer();
        logic rx_rdy;
        logic tx_rdy;
        if (avm_read && avm_address == AVM_ADDR_BITS'(STATUS_ADDR)) begin
            rx_rdy = (rx_q.size() != 0) && ($urandom % 3 != 0);
            tx_rdy = ($urandom % 3 != 0);
            avm_readdata               = 32'd0;
            avm_readdata[RX_READY_BIT] = rx_rdy;
            avm_readdata[TX_READY_BIT] = tx_rdy;
            rx_granted   = rx_rdy;
            tx_granted   = tx_rdy;
            status_reads = status_reads + 1;
        end else if (avm_read && avm_address == AVM_ADDR_BITS'(RX_ADDR)) begin
            if (!rx_granted || rx_q.size() == 0) begin
                $display("Receive register read without a status read showing a byte ready");
                proto_error = 1'b1;
            end else begin
                avm_readdata = {24'd0, rx_q.pop_front()};
            end
            rx_granted = 1'b0;
        end else if (avm_write && avm_address == AVM_ADDR_BITS'(TX_ADDR)) begin
            if (!tx_granted) begin
                $display("Transmit write without a status read showing the transmitter ready");
                proto_error = 1'b1;
            end
            tx_q.push_back(avm_writedata[7:0]);
            tx_granted = 1'b0;
        end else begin
            $display("Bus access to an undefined register at address %h", avm_address);
            proto_error = 1'b1;
        end
    endtask

    // 0 to 3 wait cycles per transfer
    always @(negedge avm_clk) begin
        if (avm_rst) begin
            avm_waitrequest = 1'b0;
            in_transfer     = 1'b0;
        end else if (avm_read || avm_write) begin
            if (!in_transfer) begin
                in_transfer = 1'b1;
                wait_left   = int'($urandom % 4);
            end
            if (wait_left > 0) begin
                wait_left       = wait_left - 1;
                avm_waitrequest = 1'b1;
            end else begin
                in_transfer     = 1'b0;
                avm_waitrequest = 1'b0;
                complete_transfer();
            end
        end else begin
            avm_waitrequest = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_rsa_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rsa_top
    import rsa_pkg::*;
();

    // Covers two core runs of about 133k cycles each plus the byte traffic
    localparam int CYCLE_LIMIT  = 400_000;
    localparam int SETTLE_POLLS = 8;

    logic                     avm_clk;
    logic                     avm_rst;
    logic [AVM_ADDR_BITS-1:0] avm_address;
    logic                     avm_read;
    logic                     avm_write;
    logic [31:0]              avm_readdata;
    logic [31:0]              avm_writedata;
    logic                     avm_waitrequest;
    logic                     proto_error;
    int                       cycle_cnt = 0;
    logic                     held = 1'b0;
    logic [AVM_ADDR_BITS-1:0] prev_address;
    logic                     prev_read;
    logic                     prev_write;
    logic [31:0]              prev_writedata;
    logic [RSA_BITS-1:0]      n1;
    logic [RSA_BITS-1:0]      d1;
    logic [RSA_BITS-1:0]      c1;
    logic [RSA_BITS-1:0]      n2;
    logic [RSA_BITS-1:0]      d2;
    logic [RSA_BITS-1:0]      c2;
    logic [RSA_BITS-1:0]      span;

    rsa_top UUT (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    avm_uart_model uart (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest),
        .proto_error     (proto_error)
    );

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    function automatic logic [RSA_BITS-1:0] random_operand();
        logic [RSA_BITS-1:0] v;
        int                  i;
        v = '0;
        for (i = 0; i < RSA_BITS / 32; i++) begin
            v = {v[RSA_BITS-33:0], $urandom};
        end
        return v;
    endfunction

    // Plain LSB-first square-and-multiply on double-width integers
    function automatic logic [RSA_BITS-1:0] reference_mod_exp(
        input logic [RSA_BITS-1:0] base,
        input logic [RSA_BITS-1:0] expo,
        input logic [RSA_BITS-1:0] modulus
    );
        logic [2*RSA_BITS-1:0] r;
        logic [2*RSA_BITS-1:0] b;
        logic [2*RSA_BITS-1:0] m;
        int                    i;
        m = {{RSA_BITS{1'b0}}, modulus};
        r = 512'd1;
        b = {{RSA_BITS{1'b0}}, base} % m;
        for (i = 0; i < RSA_BITS; i++) begin
            if (expo[i]) begin
                r = (r * b) % m;
            end
            b = (b * b) % m;
        end
        return r[RSA_BITS-1:0];
    endfunction

    task automatic queue_msb_first(input logic [RSA_BITS-1:0] value);
        int i;
        for (i = KEY_BYTES - 1; i >= 0; i--) begin
            uart.push_rx_byte(value[8*i +: 8]);
        end
    endtask

    task automatic run_message(
        input logic [RSA_BITS-1:0] n,
        input logic [RSA_BITS-1:0] d,
        input logic [RSA_BITS-1:0] c,
        input int                  base
    );
        logic [RSA_BITS-1:0] expected;
        logic [7:0]          got;
        int                  polls_start;
        int                  i;
        expected = reference_mod_exp(c, d, n);
        @(posedge avm_clk);
        queue_msb_first(n);
        queue_msb_first(d);
        queue_msb_first(c);
        while (uart.tx_count() < base + OUT_BYTES) begin
            @(posedge avm_clk);
        end
        // Wrapper should be back to polling receive status with nothing more to send
        polls_start = uart.status_reads;
        while (uart.status_reads < polls_start + SETTLE_POLLS) begin
            @(posedge avm_clk);
        end
        assert (uart.tx_count() == base + OUT_BYTES) else begin
            $display("** Error: tx byte count = %h, expected %h",
                     uart.tx_count(), base + OUT_BYTES);
            stop_with_failure();
        end
        for (i = 0; i < OUT_BYTES; i++) begin
            got = uart.tx_byte(base + i);
            assert (got == expected[8*(OUT_BYTES-1-i) +: 8]) else begin
                $display("** Error: avm_writedata byte %0d = %h, expected %h",
                         i, got, expected[8*(OUT_BYTES-1-i) +: 8]);
                stop_with_failure();
            end
        end
    endtask

    initial begin
        avm_clk = 1'b0;
        forever #50 avm_clk = ~avm_clk;
    end

    always @(posedge avm_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles before both messages came back", cycle_cnt);
            stop_with_failure();
        end
    end

    // Request held last cycle under waitrequest must not have moved
    always @(posedge avm_clk) begin
        if (!avm_rst) begin
            assert (!(avm_read && avm_write)) else begin
                $display("** Error: avm_read = %h and avm_write = %h together",
                         avm_read, avm_write);
                stop_with_failure();
            end
            assert (!avm_write || avm_address == AVM_ADDR_BITS'(TX_ADDR)) else begin
                $display("** Error: avm_address = %h on write, expected %h",
                         avm_address, AVM_ADDR_BITS'(TX_ADDR));
                stop_with_failure();
            end
            assert (!held || (avm_address === prev_address && avm_read === prev_read &&
                    avm_write === prev_write && avm_writedata === prev_writedata)) else begin
                $display("** Error: under waitrequest avm_address %h -> %h, avm_read %h -> %h",
                         prev_address, avm_address, prev_read, avm_read);
                $display("** Error: under waitrequest avm_write %h -> %h, avm_writedata %h -> %h",
                         prev_write, avm_write, prev_writedata, avm_writedata);
                stop_with_failure();
            end
            assert (!proto_error) else begin
                $display("UART model saw an access out of order or to an undefined address");
                stop_with_failure();
            end
        end
        held           = !avm_rst && avm_waitrequest && (avm_read || avm_write);
        prev_address   = avm_address;
        prev_read      = avm_read;
        prev_write     = avm_write;
        prev_writedata = avm_writedata;
    end

    initial begin
        void'($urandom(29251));
        avm_rst <= 1'b1;
        n1 = random_operand();
        n1[RSA_BITS-1] = 1'b1;
        n1[0] = 1'b1;
        d1 = random_operand();
        c1 = random_operand() % n1;
        n2 = random_operand();
        n2[RSA_BITS-1] = 1'b1;
        n2[0] = 1'b1;
        d2 = random_operand();
        // Second ciphertext lies above n
        span = ~n2;
        c2 = n2 + 256'd1 + ((span == '0) ? '0 : random_operand() % span);
        repeat (10) @(negedge avm_clk);
        avm_rst <= 1'b0;
        assert (avm_read === 1'b1 && avm_write === 1'b0 &&
                avm_address === AVM_ADDR_BITS'(STATUS_ADDR)) else begin
            $display("** Error: after reset avm_read = %h, avm_write = %h, avm_address = %h",
                     avm_read, avm_write, avm_address);
            stop_with_failure();
        end
        run_message(n1, d1, c1, 0);
        run_message(n2, d2, c2, OUT_BYTES);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mod_prep.sv
`timescale 1ns/1ps
`default_nettype none

module mod_prep
    import rsa_pkg::*;
(
    input  wire                 avm_clk,
    input  wire                 avm_rst,
    input  wire                 start,
    input  wire  [RSA_BITS-1:0] value,
    input  wire  [RSA_BITS-1:0] key_n,
    output logic [RSA_BITS-1:0] scaled,
    output logic                done
);

    logic                        busy;
    logic [$clog2(RSA_BITS)-1:0] step_cnt;
    logic [RSA_BITS-1:0]         acc;
    logic [RSA_BITS:0]           dbl;
    logic [RSA_BITS-1:0]         next_acc;

    assign scaled = acc;

    always_comb begin
        dbl = {acc, 1'b0};
        if (dbl >= {1'b0, key_n}) begin
            next_acc = RSA_BITS'(dbl - {1'b0, key_n});
        end else begin
            next_acc = dbl[RSA_BITS-1:0];
        end
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == '1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Top bit of n is set, so value < 2n and one subtract reduces it
    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc <= (value >= key_n) ? value - key_n : value;
        end else if (busy) begin
            acc <= next_acc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mont_mult.sv
`timescale 1ns/1ps
`default_nettype none

module mont_mult
    import rsa_pkg::*;
(
    input  wire                 avm_clk,
    input  wire                 avm_rst,
    input  wire                 start,
    input  wire  [RSA_BITS-1:0] op_a,
    input  wire  [RSA_BITS-1:0] op_b,
    input  wire  [RSA_BITS-1:0] key_n,
    output logic [RSA_BITS-1:0] product,
    output logic                done
);

    logic                        busy;
    logic [$clog2(RSA_BITS)-1:0] step_cnt;
    logic [RSA_BITS:0]           acc;
    logic [RSA_BITS-1:0]         a_sh;
    logic [RSA_BITS-1:0]         b_reg;
    logic [RSA_BITS:0]           acc_in;
    logic [RSA_BITS-1:0]         b_in;
    logic                        a_bit;
    logic [RSA_BITS+1:0]         sum_b;
    logic [RSA_BITS+1:0]         sum_n;

    // Below n after the closing subtract
    assign product = acc[RSA_BITS-1:0];

    // First step runs straight off the input operands
    always_comb begin
        acc_in = start ? '0 : acc;
        a_bit  = start ? op_a[0] : a_sh[0];
        b_in   = start ? op_b : b_reg;
        sum_b  = {1'b0, acc_in} + (a_bit ? {2'b00, b_in} : '0);
        sum_n  = sum_b[0] ? sum_b + {2'b00, key_n} : sum_b;
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == '1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Sum stays below 2n, so one subtract finishes the reduction
    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc   <= sum_n[RSA_BITS+1:1];
            a_sh  <= op_a >> 1;
            b_reg <= op_b;
        end else if (busy) begin
            if (step_cnt == '1) begin
                if (acc >= {1'b0, key_n}) begin
                    acc <= acc - {1'b0, key_n};
                end
            end else begin
                acc  <= sum_n[RSA_BITS+1:1];
                a_sh <= a_sh >> 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rsa_avm_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_avm_wrapper
    import rsa_pkg::*;
(
    input  wire                      avm_clk,
    input  wire                      avm_rst,
    output logic [AVM_ADDR_BITS-1:0] avm_address,
    output logic                     avm_read,
    input  wire  [31:0]              avm_readdata,
    output logic                     avm_write,
    output logic [31:0]              avm_writedata,
    input  wire                      avm_waitrequest,
    output logic                     rsa_start,
    output logic [RSA_BITS-1:0]      key_n,
    output logic [RSA_BITS-1:0]      key_d,
    output logic [RSA_BITS-1:0]      cipher,
    input  wire  [RSA_BITS-1:0]      result,
    input  wire                      finished
);

    wrapper_state_t           state;
    logic [BYTE_CNT_BITS-1:0] byte_cnt;
    logic [RSA_BITS-1:0]      out_sh;
    logic [7:0]               rx_byte;
    logic                     rx_done;
    logic                     tx_done;

    assign rx_byte = avm_readdata[7:0];
    assign rx_done = (state == read_rx_byte) && !avm_waitrequest;
    assign tx_done = (state == write_tx_byte) && !avm_waitrequest;

    // Top byte of bits 247..0, byte 31 is never sent
    assign avm_writedata = {24'd0, out_sh[RSA_BITS-9 -: 8]};

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state       <= poll_rx_status;
            byte_cnt    <= '0;
            avm_address <= AVM_ADDR_BITS'(STATUS_ADDR);
            avm_read    <= 1'b1;
            avm_write   <= 1'b0;
            rsa_start   <= 1'b0;
        end else begin
            rsa_start <= 1'b0;
            case (state)
                poll_rx_status: begin
                    // Not ready yet means the same status read runs again
                    if (!avm_waitrequest && avm_readdata[RX_READY_BIT]) begin
                        avm_address <= AVM_ADDR_BITS'(RX_ADDR);
                        state       <= read_rx_byte;
                    end
                end
                read_rx_byte: begin
                    if (!avm_waitrequest) begin
                        if (byte_cnt == BYTE_CNT_BITS'(3 * KEY_BYTES - 1)) begin
                            byte_cnt  <= '0;
                            avm_read  <= 1'b0;
                            rsa_start <= 1'b1;
                            state     <= wait_core;
                        end else begin
                            byte_cnt    <= byte_cnt + 1'b1;
                            avm_address <= AVM_ADDR_BITS'(STATUS_ADDR);
                            state       <= poll_rx_status;
                        end
                    end
                end
                wait_core: begin
                    if (finished) begin
                        avm_read    <= 1'b1;
                        avm_address <= AVM_ADDR_BITS'(STATUS_ADDR);
                        state       <= poll_tx_status;
                    end
                end
                poll_tx_status: begin
                    if (!avm_waitrequest && avm_readdata[TX_READY_BIT]) begin
                        avm_read    <= 1'b0;
                        avm_write   <= 1'b1;
                        avm_address <= AVM_ADDR_BITS'(TX_ADDR);
                        state       <= write_tx_byte;
                    end
                end
                write_tx_byte: begin
                    if (!avm_waitrequest) begin
                        avm_write   <= 1'b0;
                        avm_read    <= 1'b1;
                        avm_address <= AVM_ADDR_BITS'(STATUS_ADDR);
                        if (byte_cnt == BYTE_CNT_BITS'(OUT_BYTES - 1)) begin
                            // Next message brings its own keys
                            byte_cnt <= '0;
                            state    <= poll_rx_status;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= poll_tx_status;
                        end
                    end
                end
                default: begin
                    state <= poll_rx_status;
                end
            endcase
        end
    end

    // Key and message bytes arrive MSB first
    always_ff @(posedge avm_clk) begin
        if (rx_done) begin
            if (byte_cnt < BYTE_CNT_BITS'(KEY_BYTES)) begin
                key_n <= {key_n[RSA_BITS-9:0], rx_byte};
            end else if (byte_cnt < BYTE_CNT_BITS'(2 * KEY_BYTES)) begin
                key_d <= {key_d[RSA_BITS-9:0], rx_byte};
            end else begin
                cipher <= {cipher[RSA_BITS-9:0], rx_byte};
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == wait_core && finished) begin
            out_sh <= result;
        end else if (tx_done) begin
            out_sh <= out_sh << 8;
        end
    end

    a_no_read_write_overlap: assert property (
        @(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write)
    );

    // Pending transfer must hold its request until accepted
    a_hold_during_wait: assert property (
        @(posedge avm_clk) disable iff (avm_rst)
        (avm_waitrequest && (avm_read || avm_write)) |=>
            $stable(avm_address) && $stable(avm_read) &&
            $stable(avm_write) && $stable(avm_writedata)
    );

endmodule

`default_nettype wire

//--- verilog/rsa_core.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_core
    import rsa_pkg::*;
(
    input  wire                 avm_clk,
    input  wire                 avm_rst,
    input  wire                 start,
    input  wire  [RSA_BITS-1:0] key_n,
    input  wire  [RSA_BITS-1:0] key_d,
    input  wire  [RSA_BITS-1:0] cipher,
    output logic [RSA_BITS-1:0] result,
    output logic                finished
);

    core_state_t                 state;
    logic                        prep_start;
    logic                        prep_done;
    logic                        prep_one;
    logic                        mm_start;
    logic                        mm_done;
    logic [RSA_BITS-1:0]         prep_value;
    logic [RSA_BITS-1:0]         prep_scaled;
    logic [RSA_BITS-1:0]         mm_a;
    logic [RSA_BITS-1:0]         mm_b;
    logic [RSA_BITS-1:0]         mm_product;
    logic [RSA_BITS-1:0]         acc;
    logic [RSA_BITS-1:0]         pow;
    logic [$clog2(RSA_BITS)-1:0] bit_idx;
    logic [$clog2(RSA_BITS)-1:0] next_idx;

    // Second prep pass scales 1 to give R mod n
    assign prep_value = prep_one ? RSA_BITS'(1) : cipher;
    assign next_idx   = bit_idx + 1'b1;
    assign finished   = (state == done);
    assign result     = acc;

    always_comb begin
        case (state)
            multiply: begin
                mm_a = acc;
                mm_b = pow;
            end
            unscale: begin
                mm_a = acc;
                mm_b = RSA_BITS'(1);
            end
            default: begin
                mm_a = pow;
                mm_b = pow;
            end
        endcase
    end

    mod_prep u_mod_prep (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prep_start),
        .value   (prep_value),
        .key_n   (key_n),
        .scaled  (prep_scaled),
        .done    (prep_done)
    );

    mont_mult u_mont_mult (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mm_start),
        .op_a    (mm_a),
        .op_b    (mm_b),
        .key_n   (key_n),
        .product (mm_product),
        .done    (mm_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= idle;
            prep_start <= 1'b0;
            prep_one   <= 1'b0;
            mm_start   <= 1'b0;
            bit_idx    <= '0;
        end else begin
            prep_start <= 1'b0;
            mm_start   <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        prep_one   <= 1'b0;
                        prep_start <= 1'b1;
                        state      <= prep;
                    end
                end
                prep: begin
                    if (prep_done && !prep_one) begin
                        prep_one   <= 1'b1;
                        prep_start <= 1'b1;
                    end else if (prep_done) begin
                        bit_idx  <= '0;
                        mm_start <= 1'b1;
                        if (key_d[0]) begin
                            state <= multiply;
                        end else begin
                            state <= square;
                        end
                    end
                end
                multiply: begin
                    if (mm_done) begin
                        mm_start <= 1'b1;
                        state    <= square;
                    end
                end
                square: begin
                    if (mm_done) begin
                        mm_start <= 1'b1;
                        bit_idx  <= next_idx;
                        if (bit_idx == '1) begin
                            state <= unscale;
                        end else if (key_d[next_idx]) begin
                            state <= multiply;
                        end else begin
                            state <= square;
                        end
                    end
                end
                unscale: begin
                    if (mm_done) begin
                        state <= done;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Running power and accumulator, both in Montgomery form until unscale
    always_ff @(posedge avm_clk) begin
        if (state == prep && prep_done) begin
            if (prep_one) begin
                acc <= prep_scaled;
            end else begin
                pow <= prep_scaled;
            end
        end else if (mm_done && state == square) begin
            pow <= mm_product;
        end else if (mm_done) begin
            acc <= mm_product;
        end
    end

    a_start_only_idle: assert property (
        @(posedge avm_clk) disable iff (avm_rst)
        start |-> state == idle
    );

endmodule

`default_nettype wire

//--- verilog/rsa_pkg.sv
`default_nettype none

package rsa_pkg;

    // Operand and message sizes
    localparam int RSA_BITS      = 256;
    localparam int KEY_BYTES     = 32;
    localparam int OUT_BYTES     = 31;
    localparam int BYTE_CNT_BITS = 7;

    // UART register map on the Avalon bus
    localparam int AVM_ADDR_BITS = 5;
    localparam int RX_ADDR       = 0;
    localparam int TX_ADDR       = 4;
    localparam int STATUS_ADDR   = 8;

    // Status register bits
    localparam int TX_READY_BIT  = 6;
    localparam int RX_READY_BIT  = 7;

    typedef enum logic [2:0] {
        poll_rx_status,
        read_rx_byte,
        wait_core,
        poll_tx_status,
        write_tx_byte
    } wrapper_state_t;

    typedef enum logic [2:0] {
        idle,
        prep,
        square,
        multiply,
        unscale,
        done
    } core_state_t;

endpackage

`default_nettype wire

//--- verilog/rsa_top.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_top
    import rsa_pkg::*;
(
    input  wire                      avm_clk,
    input  wire                      avm_rst,
    output logic [AVM_ADDR_BITS-1:0] avm_address,
    output logic                     avm_read,
    input  wire  [31:0]              avm_readdata,
    output logic                     avm_write,
    output logic [31:0]              avm_writedata,
    input  wire                      avm_waitrequest
);

    logic                rsa_start;
    logic                finished;
    logic [RSA_BITS-1:0] key_n;
    logic [RSA_BITS-1:0] key_d;
    logic [RSA_BITS-1:0] cipher;
    logic [RSA_BITS-1:0] result;

    rsa_avm_wrapper u_wrapper (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .rsa_start       (rsa_start),
        .key_n           (key_n),
        .key_d           (key_d),
        .cipher          (cipher),
        .result          (result),
        .finished        (finished)
    );

    rsa_core u_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (rsa_start),
        .key_n    (key_n),
        .key_d    (key_d),
        .cipher   (cipher),
        .result   (result),
        .finished (finished)
    );

endmodule

`default_nettype wire
